//--- logic/ecc_pkg.sv
package ecc_pkg;

  // Data words carried per controller clock (two DRAM clocks, DDR).
  localparam int n_words    = 4;
  localparam int data_width = 64;
  localparam int ecc_width  = 8;
  localparam int code_width = data_width + ecc_width;
  localparam int mask_width = data_width / 8;

  localparam int cnt_width      = 16;
  localparam int apb_addr_width = 8;
  localparam int apb_data_width = 32;

  localparam logic [apb_addr_width-1:0] reg_ctrl       = 8'h00;
  localparam logic [apb_addr_width-1:0] reg_inject     = 8'h04;
  localparam logic [apb_addr_width-1:0] reg_corr_cnt   = 8'h08;
  localparam logic [apb_addr_width-1:0] reg_uncorr_cnt = 8'h0C;
  localparam logic [apb_addr_width-1:0] reg_syndrome   = 8'h10;

  // One row per check bit, indexed by code word bit position.
  typedef logic [ecc_width-1:0][code_width-1:0] h_rows_t;

  typedef struct packed {
    logic [n_words-1:0][data_width-1:0] data;
    logic [n_words-1:0][mask_width-1:0] mask;
    logic [n_words-1:0][data_width-1:0] merge;
    logic [n_words-1:0]                 raw;
  } wr_req_t;

  // Each code word is {check bits, data}.
  typedef struct packed {
    logic [n_words-1:0][code_width-1:0] word;
  } code_beat_t;

  typedef struct packed {
    logic [n_words-1:0][data_width-1:0] data;
    logic [n_words-1:0]                 corrected;
    logic [n_words-1:0]                 uncorr;
  } rd_rsp_t;

  typedef struct packed {
    logic [2:0]           corr_inc;
    logic [2:0]           uncorr_inc;
    logic                 syn_valid;
    logic [ecc_width-1:0] syndrome;
  } err_evt_t;

  typedef struct packed {
    logic                      psel;
    logic                      penable;
    logic                      pwrite;
    logic [apb_addr_width-1:0] paddr;
    logic [apb_data_width-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [apb_data_width-1:0] prdata;
    logic                      pready;
    logic                      pslverr;
  } apb_rsp_t;

endpackage

//--- logic/ecc_hmatrix.sv
`timescale 1ns/1ps

module ecc_hmatrix (
  output ecc_pkg::h_rows_t h_rows
);

  import ecc_pkg::*;

  // Hsiao code: every data column is a distinct odd-weight vector of weight
  // 3 or 5, taken in ascending numerical order. Check columns are unit vectors,
  // so every column has odd weight and none is zero.
  function automatic h_rows_t build_rows();
    h_rows_t        rows;
    int unsigned    col;
    logic [7:0]     v;
    int unsigned    weight;
    rows = '0;
    col  = 0;
    for (int val = 1; val < 256; val++) begin
      v      = 8'(val);
      weight = $countones(v);
      if (col < data_width && (weight == 3 || weight == 5)) begin
        for (int j = 0; j < ecc_width; j++) begin
          rows[j][col] = v[j];
        end
        col++;
      end
    end
    for (int j = 0; j < ecc_width; j++) begin
      rows[j][data_width+j] = 1'b1;
    end
    return rows;
  endfunction

  assign h_rows = build_rows();

endmodule

//--- logic/ecc_merge_enc.sv
`timescale 1ns/1ps

module ecc_merge_enc (
  input  logic                          clk,
  input  logic                          arst_n,
  input  logic                          wr_valid,
  input  ecc_pkg::wr_req_t              wr_req,
  input  ecc_pkg::h_rows_t              h_rows,
  input  logic                          ecc_en,
  input  logic [ecc_pkg::ecc_width-1:0] inject,
  output logic                          mc_wrvalid,
  output ecc_pkg::code_beat_t           mc_wrdata
);

  import ecc_pkg::*;

  logic                               valid_q;
  wr_req_t                            req_q;
  logic [n_words-1:0][data_width-1:0] merged;
  logic [n_words-1:0]                 raw_w;
  logic [n_words-1:0][ecc_width-1:0]  check;
  code_beat_t                         code_c;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_q    <= 1'b0;
      mc_wrvalid <= 1'b0;
    end else begin
      valid_q    <= wr_valid;
      mc_wrvalid <= valid_q;
    end
  end

  always_ff @(posedge clk) begin
    req_q     <= wr_req;
    mc_wrdata <= code_c;
  end

  // A set mask bit means the byte is not written by the user, so it is
  // taken from the read-merge data instead.
  always_comb begin
    for (int w = 0; w < n_words; w++) begin
      for (int b = 0; b < mask_width; b++) begin
        merged[w][b*8 +: 8] = req_q.mask[w][b] ? req_q.merge[w][b*8 +: 8]
                                               : req_q.data[w][b*8 +: 8];
      end
    end
  end

  assign raw_w = req_q.raw | {n_words{~ecc_en}};

  always_comb begin
    for (int w = 0; w < n_words; w++) begin
      for (int j = 0; j < ecc_width; j++) begin
        check[w][j] = raw_w[w] ? 1'b0 : ^(merged[w] & h_rows[j][data_width-1:0]);
      end
    end
    // Fault injection corrupts only word 0, and only when it carries ECC.
    if (!raw_w[0]) begin
      check[0] = check[0] ^ inject;
    end
  end

  always_comb begin
    for (int w = 0; w < n_words; w++) begin
      code_c.word[w] = {check[w], merged[w]};
    end
  end

endmodule

//--- logic/ecc_dec_fix.sv
`timescale 1ns/1ps

module ecc_dec_fix (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                phy_rdvalid,
  input  ecc_pkg::code_beat_t phy_rddata,
  input  ecc_pkg::h_rows_t    h_rows,
  input  logic                ecc_en,
  output logic                rd_valid,
  output ecc_pkg::rd_rsp_t    rd_rsp,
  output ecc_pkg::err_evt_t   err_evt
);

  import ecc_pkg::*;

  logic                               valid_q;
  code_beat_t                         beat_q;
  logic [code_width-1:0][ecc_width-1:0] h_cols;
  logic [n_words-1:0][ecc_width-1:0]  syn;
  logic [n_words-1:0]                 hit;
  rd_rsp_t                            rsp_c;
  err_evt_t                           evt_c;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_q  <= 1'b0;
      rd_valid <= 1'b0;
      err_evt  <= '0;
    end else begin
      valid_q  <= phy_rdvalid;
      rd_valid <= valid_q;
      err_evt  <= valid_q ? evt_c : '0;
    end
  end

  always_ff @(posedge clk) begin
    beat_q <= phy_rddata;
    rd_rsp <= rsp_c;
  end

  always_comb begin
    for (int k = 0; k < code_width; k++) begin
      for (int j = 0; j < ecc_width; j++) begin
        h_cols[k][j] = h_rows[j][k];
      end
    end
  end

  always_comb begin
    for (int w = 0; w < n_words; w++) begin
      for (int j = 0; j < ecc_width; j++) begin
        syn[w][j] = ^(beat_q.word[w] & h_rows[j]);
      end
    end
  end

  // All columns are odd weight and nonzero, so a column match already implies
  // a nonzero odd syndrome. A match on a check column needs no data fix.
  always_comb begin
    for (int w = 0; w < n_words; w++) begin
      hit[w]        = 1'b0;
      rsp_c.data[w] = beat_q.word[w][data_width-1:0];
      for (int k = 0; k < code_width; k++) begin
        if (h_cols[k] == syn[w]) begin
          hit[w] = 1'b1;
        end
      end
      for (int k = 0; k < data_width; k++) begin
        if (ecc_en && h_cols[k] == syn[w]) begin
          rsp_c.data[w][k] = ~beat_q.word[w][k];
        end
      end
      rsp_c.corrected[w] = ecc_en & hit[w];
      rsp_c.uncorr[w]    = ecc_en & ~hit[w] & (|syn[w]);
    end
  end

  always_comb begin
    evt_c = '0;
    for (int w = 0; w < n_words; w++) begin
      evt_c.corr_inc   = evt_c.corr_inc + 3'(rsp_c.corrected[w]);
      evt_c.uncorr_inc = evt_c.uncorr_inc + 3'(rsp_c.uncorr[w]);
    end
    // Scan downwards so the lowest failing word is the one logged.
    for (int w = n_words - 1; w >= 0; w--) begin
      if (ecc_en && |syn[w]) begin
        evt_c.syn_valid = 1'b1;
        evt_c.syndrome  = syn[w];
      end
    end
  end

endmodule

//--- logic/ecc_apb_regs.sv
`timescale 1ns/1ps

module ecc_apb_regs (
  input  logic                          clk,
  input  logic                          arst_n,
  input  ecc_pkg::apb_req_t             apb_req,
  output ecc_pkg::apb_rsp_t             apb_rsp,
  input  ecc_pkg::err_evt_t             err_evt,
  output logic                          ecc_en,
  output logic [ecc_pkg::ecc_width-1:0] inject
);

  import ecc_pkg::*;

  logic                 access;
  logic                 wr_en;
  logic                 addr_ok;
  logic [cnt_width-1:0] corr_cnt;
  logic [cnt_width-1:0] uncorr_cnt;
  logic [ecc_width-1:0] syndrome;

  function automatic logic [cnt_width-1:0] sat_add(input logic [cnt_width-1:0] cnt,
                                                  input logic [2:0]           inc);
    logic [cnt_width:0] sum;
    sum = {1'b0, cnt} + {{(cnt_width - 2){1'b0}}, inc};
    return sum[cnt_width] ? '1 : sum[cnt_width-1:0];
  endfunction

  assign access = apb_req.psel & apb_req.penable;
  assign wr_en  = access & apb_req.pwrite;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ecc_en     <= 1'b1;
      inject     <= '0;
      corr_cnt   <= '0;
      uncorr_cnt <= '0;
      syndrome   <= '0;
    end else begin
      if (wr_en && apb_req.paddr == reg_ctrl) begin
        ecc_en <= apb_req.pwdata[0];
      end
      if (wr_en && apb_req.paddr == reg_inject) begin
        inject <= apb_req.pwdata[ecc_width-1:0];
      end
      // A software clear takes priority over a decoder event in the same cycle.
      if (wr_en && apb_req.paddr == reg_corr_cnt) begin
        corr_cnt <= '0;
      end else begin
        corr_cnt <= sat_add(corr_cnt, err_evt.corr_inc);
      end
      if (wr_en && apb_req.paddr == reg_uncorr_cnt) begin
        uncorr_cnt <= '0;
      end else begin
        uncorr_cnt <= sat_add(uncorr_cnt, err_evt.uncorr_inc);
      end
      if (err_evt.syn_valid) begin
        syndrome <= err_evt.syndrome;
      end
    end
  end

  always_comb begin
    apb_rsp.prdata = '0;
    apb_rsp.pready = 1'b1;
    addr_ok        = 1'b1;
    case (apb_req.paddr)
      reg_ctrl:       apb_rsp.prdata = apb_data_width'(ecc_en);
      reg_inject:     apb_rsp.prdata = apb_data_width'(inject);
      reg_corr_cnt:   apb_rsp.prdata = apb_data_width'(corr_cnt);
      reg_uncorr_cnt: apb_rsp.prdata = apb_data_width'(uncorr_cnt);
      reg_syndrome:   apb_rsp.prdata = apb_data_width'(syndrome);
      default:        addr_ok        = 1'b0;
    endcase
    // The syndrome log is read-only.
    apb_rsp.pslverr = access & (~addr_ok | (apb_req.pwrite & apb_req.paddr == reg_syndrome));
  end

endmodule

//--- logic/ecc_top.sv
`timescale 1ns/1ps

module ecc_top (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                wr_valid,
  input  ecc_pkg::wr_req_t    wr_req,
  output logic                mc_wrvalid,
  output ecc_pkg::code_beat_t mc_wrdata,
  input  logic                phy_rdvalid,
  input  ecc_pkg::code_beat_t phy_rddata,
  output logic                rd_valid,
  output ecc_pkg::rd_rsp_t    rd_rsp,
  input  ecc_pkg::apb_req_t   apb_req,
  output ecc_pkg::apb_rsp_t   apb_rsp
);

  import ecc_pkg::*;

  h_rows_t              h_rows;
  logic                 ecc_en;
  logic [ecc_width-1:0] inject;
  err_evt_t             err_evt;

  ecc_hmatrix ecc_hmatrix_i (
    .h_rows (h_rows)
  );

  ecc_merge_enc ecc_merge_enc_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .wr_valid   (wr_valid),
    .wr_req     (wr_req),
    .h_rows     (h_rows),
    .ecc_en     (ecc_en),
    .inject     (inject),
    .mc_wrvalid (mc_wrvalid),
    .mc_wrdata  (mc_wrdata)
  );

  ecc_dec_fix ecc_dec_fix_i (
    .clk         (clk),
    .arst_n      (arst_n),
    .phy_rdvalid (phy_rdvalid),
    .phy_rddata  (phy_rddata),
    .h_rows      (h_rows),
    .ecc_en      (ecc_en),
    .rd_valid    (rd_valid),
    .rd_rsp      (rd_rsp),
    .err_evt     (err_evt)
  );

  ecc_apb_regs ecc_apb_regs_i (
    .clk     (clk),
    .arst_n  (arst_n),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp),
    .err_evt (err_evt),
    .ecc_en  (ecc_en),
    .inject  (inject)
  );

endmodule

//--- testbench/ecc_tb.sv
`timescale 1ns/1ps

module ecc_tb;

  import ecc_pkg::*;

  localparam int wait_limit = 40;
  localparam int n_cases    = 9;

  // One row of the stimulus table. A flip position of -1 means no flip.
  typedef struct packed {
    logic              ecc_en;
    logic [7:0]        inject;
    logic [3:0]        raw;
    logic              rand_mask;
    logic [1:0]        beats;
    logic              loopback;
    logic [1:0]        flip_word;
    logic signed [7:0] flip_a;
    logic signed [7:0] flip_b;
    logic [3:0]        exp_corr;
    logic [3:0]        exp_uncorr;
  } case_t;

  logic        clk;
  logic        arst_n;
  logic        wr_valid;
  wr_req_t     wr_req;
  logic        mc_wrvalid;
  code_beat_t  mc_wrdata;
  logic        phy_rdvalid;
  code_beat_t  phy_rddata;
  logic        rd_valid;
  rd_rsp_t     rd_rsp;
  apb_req_t    apb_req;
  apb_rsp_t    apb_rsp;

  int          cycle      = 0;
  int          n_checks   = 0;
  int          n_errors   = 0;
  logic [15:0] lfsr_state = 16'd40407;
  logic [7:0]  last_syn   = 8'h00;
  logic [7:0]  tb_col [code_width];
  case_t       cases [n_cases];
  code_beat_t  wr_seen [$];
  int          wr_seen_edge [$];
  rd_rsp_t     rd_seen [$];
  int          rd_seen_edge [$];
  code_beat_t  exp_beat [2];
  int          sent_edge [2];

  ecc_top ecc_top_i (
    .clk         (clk),
    .arst_n      (arst_n),
    .wr_valid    (wr_valid),
    .wr_req      (wr_req),
    .mc_wrvalid  (mc_wrvalid),
    .mc_wrdata   (mc_wrdata),
    .phy_rdvalid (phy_rdvalid),
    .phy_rddata  (phy_rddata),
    .rd_valid    (rd_valid),
    .rd_rsp      (rd_rsp),
    .apb_req     (apb_req),
    .apb_rsp     (apb_rsp)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  // Outputs are captured at the falling edge, tagged with the rising edge that produced them.
  always @(negedge clk) begin
    if (mc_wrvalid) begin
      wr_seen.push_back(mc_wrdata);
      wr_seen_edge.push_back(cycle - 1);
    end
    if (rd_valid) begin
      rd_seen.push_back(rd_rsp);
      rd_seen_edge.push_back(cycle - 1);
    end
  end

  // Galois form of x^16 + x^14 + x^13 + x^11 + 1.
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 16'hB400;
    end
    return s >> 1;
  endfunction

  task automatic take_bits(input int n, output logic [63:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[62:0], lfsr_state[0]};
    end
  endtask

  // Data columns are the values of weight 3 or 5 in ascending order.
  // Check columns are unit vectors.
  function automatic void build_columns();
    int         col;
    logic [7:0] vb;
    col = 0;
    for (int v = 0; v < 256; v++) begin
      vb = v[7:0];
      if (col < data_width && ($countones(vb) == 3 || $countones(vb) == 5)) begin
        tb_col[col] = vb;
        col++;
      end
    end
    for (int j = 0; j < ecc_width; j++) begin
      tb_col[data_width+j] = 8'h01 << j;
    end
  endfunction

  function automatic logic [71:0] encode_word(input logic [63:0] d, input logic raw,
                                              input logic [7:0] pat);
    logic [7:0] chk;
    chk = 8'h00;
    if (raw) begin
      return {8'h00, d};
    end
    for (int k = 0; k < data_width; k++) begin
      if (d[k]) begin
        chk = chk ^ tb_col[k];
      end
    end
    return {chk ^ pat, d};
  endfunction

  function automatic logic [7:0] word_syndrome(input logic [71:0] cw);
    logic [7:0] s;
    s = 8'h00;
    for (int k = 0; k < code_width; k++) begin
      if (cw[k]) begin
        s = s ^ tb_col[k];
      end
    end
    return s;
  endfunction

  function automatic void load_cases();
    cases[0] = '{1'b1, 8'h00, 4'h0, 1'b1, 2'd2, 1'b1, 2'd0, -8'sd1, -8'sd1, 4'h0, 4'h0};
    cases[1] = '{1'b1, 8'h00, 4'h0, 1'b1, 2'd1, 1'b1, 2'd1, 8'sd17, -8'sd1, 4'h2, 4'h0};
    cases[2] = '{1'b1, 8'h00, 4'h0, 1'b1, 2'd1, 1'b1, 2'd2, 8'sd67, -8'sd1, 4'h4, 4'h0};
    cases[3] = '{1'b1, 8'h00, 4'h0, 1'b0, 2'd1, 1'b1, 2'd3, 8'sd5, 8'sd40, 4'h0, 4'h8};
    cases[4] = '{1'b1, 8'h5A, 4'hB, 1'b1, 2'd2, 1'b0, 2'd0, -8'sd1, -8'sd1, 4'h0, 4'h0};
    cases[5] = '{1'b0, 8'h00, 4'h0, 1'b1, 2'd1, 1'b1, 2'd0, -8'sd1, -8'sd1, 4'h0, 4'h0};
    cases[6] = '{1'b1, 8'h10, 4'h0, 1'b0, 2'd1, 1'b1, 2'd0, -8'sd1, -8'sd1, 4'h1, 4'h0};
    cases[7] = '{1'b1, 8'h03, 4'h0, 1'b1, 2'd1, 1'b1, 2'd0, -8'sd1, -8'sd1, 4'h0, 4'h1};
    cases[8] = '{1'b1, 8'h00, 4'h0, 1'b1, 2'd2, 1'b1, 2'd0, 8'sd63, -8'sd1, 4'h1, 4'h0};
  endfunction

  task automatic check_value(input string what, input logic [127:0] got,
                             input logic [127:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("Mismatch at %0t: %s got %0h expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic abort_run(input string why);
    $display("Run stopped at %0t: %s", $time, why);
    $display("Checks run: %0d, mismatches: %0d, timeouts: 1", n_checks, n_errors);
    $display("TEST RESULT: FAIL");
    $finish;
  endtask

  task automatic wait_for_beats(input logic rd_side, input int count);
    int n;
    n = 0;
    while ((rd_side ? rd_seen.size() : wr_seen.size()) < count) begin
      if (n == wait_limit) begin
        abort_run(rd_side ? "no read response from the decoder" : "no code word from the encoder");
      end else begin
        @(posedge clk);
        n++;
      end
    end
  endtask

  task automatic apb_access(input logic write, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic slverr);
    int n;
    @(posedge clk);
    apb_req.psel    <= 1'b1;
    apb_req.penable <= 1'b0;
    apb_req.pwrite  <= write;
    apb_req.paddr   <= addr;
    apb_req.pwdata  <= wdata;
    @(posedge clk);
    apb_req.penable <= 1'b1;
    n = 0;
    @(negedge clk);
    while (!apb_rsp.pready) begin
      if (n == wait_limit) begin
        abort_run("APB slave never raised pready");
      end else begin
        @(negedge clk);
        n++;
      end
    end
    rdata  = apb_rsp.prdata;
    slverr = apb_rsp.pslverr;
    @(posedge clk);
    apb_req.psel    <= 1'b0;
    apb_req.penable <= 1'b0;
  endtask

  task automatic reg_write(input logic [7:0] addr, input logic [31:0] data);
    logic [31:0] rdata;
    logic        slverr;
    apb_access(1'b1, addr, data, rdata, slverr);
    check_value($sformatf("pslverr on write to %0h", addr), slverr, 1'b0);
  endtask

  task automatic reg_check(input logic [7:0] addr, input logic [31:0] exp, input string what);
    logic [31:0] rdata;
    logic        slverr;
    apb_access(1'b0, addr, 32'h0, rdata, slverr);
    check_value(what, rdata, exp);
    check_value($sformatf("pslverr on read of %0h", addr), slverr, 1'b0);
  endtask

  task automatic run_case(input int idx);
    case_t      c;
    wr_req_t    req;
    code_beat_t got_beat;
    code_beat_t looped;
    rd_rsp_t    got_rsp;
    int         got_edge;
    int         rd_edge;
    logic       found;
    logic [7:0] syn;
    c = cases[idx];
    reg_write(reg_ctrl, 32'(c.ecc_en));
    reg_write(reg_inject, 32'(c.inject));
    reg_write(reg_corr_cnt, 32'h0);
    reg_write(reg_uncorr_cnt, 32'h0);
    for (int b = 0; b < c.beats; b++) begin
      req = '0;
      for (int w = 0; w < n_words; w++) begin
        take_bits(64, req.data[w]);
        take_bits(64, req.merge[w]);
        take_bits(8, got_beat.word[w][63:0]);
        req.mask[w] = c.rand_mask ? got_beat.word[w][7:0] : 8'h00;
        req.raw[w]  = c.raw[w];
        for (int k = 0; k < mask_width; k++) begin
          syn = req.mask[w][k] ? req.merge[w][k*8 +: 8] : req.data[w][k*8 +: 8];
          exp_beat[b].word[w][k*8 +: 8] = syn;
        end
        found = c.raw[w] | ~c.ecc_en;
        exp_beat[b].word[w] = encode_word(exp_beat[b].word[w][63:0], found,
                                          (w == 0) ? c.inject : 8'h00);
      end
      @(posedge clk);
      wr_req   <= req;
      wr_valid <= 1'b1;
      sent_edge[b] = cycle;
    end
    @(posedge clk);
    wr_valid <= 1'b0;
    wait_for_beats(1'b0, c.beats);
    for (int b = 0; b < c.beats; b++) begin
      got_beat = wr_seen.pop_front();
      got_edge = wr_seen_edge.pop_front();
      check_value($sformatf("case %0d beat %0d write latency", idx, b),
                  got_edge - sent_edge[b], 2);
      for (int w = 0; w < n_words; w++) begin
        check_value($sformatf("case %0d beat %0d code word %0d", idx, b, w),
                    got_beat.word[w], exp_beat[b].word[w]);
      end
      if (b == 0) begin
        looped = got_beat;
      end
    end
    if (c.loopback) begin
      if (c.flip_a >= 0) begin
        looped.word[c.flip_word][c.flip_a] = ~looped.word[c.flip_word][c.flip_a];
      end
      if (c.flip_b >= 0) begin
        looped.word[c.flip_word][c.flip_b] = ~looped.word[c.flip_word][c.flip_b];
      end
      @(posedge clk);
      phy_rddata  <= looped;
      phy_rdvalid <= 1'b1;
      rd_edge = cycle;
      @(posedge clk);
      phy_rdvalid <= 1'b0;
      wait_for_beats(1'b1, 1);
      got_rsp  = rd_seen.pop_front();
      got_edge = rd_seen_edge.pop_front();
      check_value($sformatf("case %0d read latency", idx), got_edge - rd_edge, 2);
      // An uncorrectable word comes back as it was received.
      for (int w = 0; w < n_words; w++) begin
        check_value($sformatf("case %0d read data word %0d", idx, w), got_rsp.data[w],
                    c.exp_uncorr[w] ? looped.word[w][data_width-1:0]
                                    : exp_beat[0].word[w][data_width-1:0]);
      end
      check_value($sformatf("case %0d corrected flags", idx), got_rsp.corrected, c.exp_corr);
      check_value($sformatf("case %0d uncorrectable flags", idx), got_rsp.uncorr, c.exp_uncorr);
      found = 1'b0;
      for (int w = 0; w < n_words; w++) begin
        syn = word_syndrome(looped.word[w]);
        if (c.ecc_en && !found && syn != 8'h00) begin
          found    = 1'b1;
          last_syn = syn;
        end
      end
      reg_check(reg_corr_cnt, $countones(c.exp_corr), $sformatf("case %0d corr_cnt", idx));
      reg_check(reg_uncorr_cnt, $countones(c.exp_uncorr), $sformatf("case %0d uncorr_cnt", idx));
      reg_check(reg_syndrome, last_syn, $sformatf("case %0d syndrome", idx));
    end
  endtask

  initial begin
    logic [31:0] rdata;
    logic        slverr;
    clk         = 1'b0;
    arst_n      = 1'b0;
    wr_valid    = 1'b0;
    wr_req      = '0;
    phy_rdvalid = 1'b0;
    phy_rddata  = '0;
    apb_req     = '0;
    build_columns();
    load_cases();
    repeat (3) @(posedge clk);
    arst_n <= 1'b1;

    reg_check(reg_ctrl, 32'h1, "ctrl after reset");
    reg_check(reg_inject, 32'h0, "inject after reset");
    reg_check(reg_corr_cnt, 32'h0, "corr_cnt after reset");
    reg_check(reg_uncorr_cnt, 32'h0, "uncorr_cnt after reset");
    reg_check(reg_syndrome, 32'h0, "syndrome after reset");

    for (int i = 0; i < n_cases; i++) begin
      run_case(i);
    end

    // The last table row leaves one corrected error behind.
    reg_check(reg_corr_cnt, 32'h1, "corr_cnt before clear");
    reg_write(reg_corr_cnt, 32'hFFFF);
    reg_check(reg_corr_cnt, 32'h0, "corr_cnt after clear");
    apb_access(1'b0, 8'h14, 32'h0, rdata, slverr);
    check_value("pslverr on unmapped offset", slverr, 1'b1);
    apb_access(1'b1, reg_syndrome, 32'h55, rdata, slverr);
    check_value("pslverr on syndrome write", slverr, 1'b1);
    reg_check(reg_syndrome, last_syn, "syndrome after refused write");
    check_value("unexpected code words after the last case", wr_seen.size(), 0);
    check_value("unexpected read responses after the last case", rd_seen.size(), 0);

    $display("Checks run: %0d, mismatches: %0d, timeouts: 0", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- vlog.f
logic/ecc_pkg.sv
logic/ecc_hmatrix.sv
logic/ecc_merge_enc.sv
logic/ecc_dec_fix.sv
logic/ecc_apb_regs.sv
logic/ecc_top.sv
testbench/ecc_tb.sv

//--- Bender.yml
package:
  name: ecc_datapath

sources:
  - logic/ecc_pkg.sv
  - logic/ecc_hmatrix.sv
  - logic/ecc_merge_enc.sv
  - logic/ecc_dec_fix.sv
  - logic/ecc_apb_regs.sv
  - logic/ecc_top.sv
  - target: simulation
    files:
      - testbench/ecc_tb.sv
